// File: verilog/workgroup_pkg.sv
// Workgroup constants, hart and debug data types, region codes and the debug address union
`default_nettype none

package workgroup_pkg;

    // Slot positions in the workgroup
    localparam int CFG_CPU_MAX = 4;
    localparam int CFG_LOG2_CPU_MAX = 2;

    typedef logic [CFG_LOG2_CPU_MAX-1:0] hartsel_t;
    typedef logic [CFG_CPU_MAX-1:0] hart_mask_t;
    typedef logic [31:0] dport_data_t;

    // Address regions, codes 2 and 3 are unmapped
    typedef enum logic [1:0] {
        REGION_CSR = 2'd0,
        REGION_GPR = 2'd1
    } dport_region_e;

    localparam int DPORT_INDEX_BITS = 10;
    typedef logic [DPORT_INDEX_BITS-1:0] dport_index_t;

    typedef struct packed {
        dport_region_e region;
        dport_index_t index;
    } dport_addr_fields_t;

    // Raw word as seen on the ports, field view as used by the decoder
    typedef union packed {
        logic [11:0] raw;
        dport_addr_fields_t fld;
    } dport_addr_u;

    // Readable control registers
    localparam dport_index_t CSR_INDEX_STATUS = 10'd0;
    localparam dport_index_t CSR_INDEX_MIP = 10'd1;

    // Debug-visible general registers per hart
    localparam int GPR_TOTAL = 8;

    // Interrupt bit positions in mip
    localparam int IRQ_MSIP = 3;
    localparam int IRQ_MTIP = 7;
    localparam int IRQ_SEIP = 9;
    localparam int IRQ_MEIP = 11;

endpackage : workgroup_pkg

`default_nettype wire

// File: verilog/dport_req_if.sv
// Decoded debug request plus halt and resume strobes shared by the slots and the response mux
`default_nettype none

interface dport_req_if;
    import workgroup_pkg::*;

    logic req_strobe;
    hartsel_t hart;
    dport_addr_u addr;
    logic write;
    dport_data_t wdata;
    // Hart not populated or region unmapped
    logic no_target;
    logic halt_strobe;
    logic resume_strobe;
    hartsel_t halt_hart;

    modport source (
        output req_strobe, hart, addr, write, wdata, no_target,
        output halt_strobe, resume_strobe, halt_hart
    );

    modport slot (
        input req_strobe, hart, addr, write, wdata, no_target,
        input halt_strobe, resume_strobe, halt_hart
    );

    modport monitor (input req_strobe, no_target);

endinterface : dport_req_if

`default_nettype wire

// File: verilog/dport_resp_if.sv
// One response lane from a hart slot toward the response mux
`default_nettype none

interface dport_resp_if;
    import workgroup_pkg::*;

    // One-cycle pulse per answered request
    logic resp_strobe;
    logic resp_error;
    dport_data_t rdata;

    modport slot (
        output resp_strobe,
        output resp_error,
        output rdata
    );

    modport mux (
        input resp_strobe,
        input resp_error,
        input rdata
    );

endinterface : dport_resp_if

`default_nettype wire

// File: verilog/dport_req_decoder.sv
// Debug request decoder with ready handshake, target check and halt/resume strobes
`default_nettype none

module dport_req_decoder #(
    parameter int cpu_num = 3
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  workgroup_pkg::hartsel_t   i_hartsel,
    input  logic                      i_haltreq,
    input  logic                      i_resumereq,
    input  logic                      i_dport_req_valid,
    input  logic                      i_dport_write,
    input  workgroup_pkg::dport_addr_u i_dport_addr,
    input  workgroup_pkg::dport_data_t i_dport_wdata,
    // Response leaves the port this cycle
    input  logic                      i_resp_done,
    output logic                      o_dport_req_ready,
    dport_req_if.source               o_req
);
    import workgroup_pkg::*;

    logic ready_q;
    logic req_accept;
    logic hart_populated;
    logic region_mapped;

    assign req_accept = i_dport_req_valid & ready_q;
    assign hart_populated = int'(i_hartsel) < cpu_num;
    assign region_mapped = (i_dport_addr.fld.region == REGION_CSR) ||
                           (i_dport_addr.fld.region == REGION_GPR);

    assign o_dport_req_ready = ready_q;

    // Handshake and strobes
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ready_q <= 1'b1;
            o_req.req_strobe <= 1'b0;
            o_req.halt_strobe <= 1'b0;
            o_req.resume_strobe <= 1'b0;
        end else begin
            o_req.req_strobe <= req_accept;
            // Only one request in flight
            if (req_accept) begin
                ready_q <= 1'b0;
            end else if (i_resp_done) begin
                ready_q <= 1'b1;
            end
            // Requests to empty slots are dropped here
            o_req.halt_strobe <= i_haltreq & hart_populated;
            o_req.resume_strobe <= i_resumereq & hart_populated;
        end
    end

    // Request payload, held until the next acceptance
    always_ff @(posedge i_clk) begin
        if (req_accept) begin
            o_req.hart <= i_hartsel;
            o_req.addr <= i_dport_addr;
            o_req.write <= i_dport_write;
            o_req.wdata <= i_dport_wdata;
            o_req.no_target <= !(hart_populated && region_mapped);
        end
        if (i_haltreq || i_resumereq) begin
            o_req.halt_hart <= i_hartsel;
        end
    end

endmodule : dport_req_decoder

`default_nettype wire

// File: verilog/hart_slot.sv
// Hart slot with halt state, general registers, status and mip registers and its response lane
`default_nettype none

module hart_slot (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  workgroup_pkg::hartsel_t i_hart_id,
    input  logic                    i_msip,
    input  logic                    i_mtip,
    input  logic                    i_meip,
    input  logic                    i_seip,
    dport_req_if.slot               i_req,
    dport_resp_if.slot              o_resp,
    output logic                    o_halted
);
    import workgroup_pkg::*;

    localparam int GPR_IDX_BITS = $clog2(GPR_TOTAL);

    logic halted_q;
    dport_data_t gpr_q [GPR_TOTAL];
    dport_data_t mip_q;
    dport_data_t mip_next;
    logic req_sel;
    logic gpr_wr;
    logic resp_err;
    dport_data_t rd_val;
    logic [GPR_IDX_BITS-1:0] gpr_idx;

    // Request for this hart that passed the decoder check
    assign req_sel = i_req.req_strobe && (i_req.hart == i_hart_id) && !i_req.no_target;
    assign gpr_idx = i_req.addr.fld.index[GPR_IDX_BITS-1:0];

    // Halt and resume, halt wins if both arrive together
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            halted_q <= 1'b0;
        end else if (i_req.halt_strobe && (i_req.halt_hart == i_hart_id)) begin
            halted_q <= 1'b1;
        end else if (i_req.resume_strobe && (i_req.halt_hart == i_hart_id)) begin
            halted_q <= 1'b0;
        end
    end

    always_comb begin
        mip_next = '0;
        mip_next[IRQ_MSIP] = i_msip;
        mip_next[IRQ_MTIP] = i_mtip;
        mip_next[IRQ_SEIP] = i_seip;
        mip_next[IRQ_MEIP] = i_meip;
    end

    // Interrupt lines sampled every cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mip_q <= '0;
        end else begin
            mip_q <= mip_next;
        end
    end

    // Access check and read data
    always_comb begin
        resp_err = 1'b0;
        rd_val = '0;
        if (i_req.addr.fld.region == REGION_CSR) begin
            // CSRs are read-only here
            if (i_req.write) begin
                resp_err = 1'b1;
            end else if (i_req.addr.fld.index == CSR_INDEX_STATUS) begin
                rd_val = dport_data_t'(halted_q);
            end else if (i_req.addr.fld.index == CSR_INDEX_MIP) begin
                rd_val = mip_q;
            end else begin
                resp_err = 1'b1;
            end
        end else begin
            if (i_req.addr.fld.index >= dport_index_t'(GPR_TOTAL)) begin
                resp_err = 1'b1;
            end else if (i_req.write) begin
                // Registers are writable only while halted
                resp_err = !halted_q;
            end else begin
                rd_val = gpr_q[gpr_idx];
            end
        end
    end

    assign gpr_wr = req_sel && i_req.write && !resp_err;

    always_ff @(posedge i_clk) begin
        if (gpr_wr) begin
            gpr_q[gpr_idx] <= i_req.wdata;
        end
    end

    // Response lane
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_resp.resp_strobe <= 1'b0;
            o_resp.resp_error <= 1'b0;
        end else begin
            o_resp.resp_strobe <= req_sel;
            o_resp.resp_error <= req_sel & resp_err;
        end
    end

    always_ff @(posedge i_clk) begin
        if (req_sel) begin
            o_resp.rdata <= resp_err ? '0 : rd_val;
        end
    end

    assign o_halted = halted_q;

endmodule : hart_slot

`default_nettype wire

// File: verilog/dport_resp_mux.sv
// Response mux over the slot lanes with decoder error path and halted vector output
`default_nettype none

module dport_resp_mux (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  workgroup_pkg::hart_mask_t  i_halted_slots,
    dport_req_if.monitor               i_req,
    dport_resp_if.mux                  i_resp [workgroup_pkg::CFG_CPU_MAX],
    output logic                       o_dport_resp_valid,
    output logic                       o_dport_resp_error,
    output workgroup_pkg::dport_data_t o_dport_rdata,
    output logic                       o_resp_done,
    output workgroup_pkg::hart_mask_t  o_halted
);
    import workgroup_pkg::*;

    hart_mask_t lane_strobe;
    hart_mask_t lane_error;
    dport_data_t lane_rdata [CFG_CPU_MAX];
    dport_data_t any_rdata;
    logic no_target_q;

    // Lanes are qualified by their strobe so idle lanes add nothing to the OR
    for (genvar i = 0; i < CFG_CPU_MAX; i++) begin : g_lane
        assign lane_strobe[i] = i_resp[i].resp_strobe;
        assign lane_error[i] = i_resp[i].resp_error & i_resp[i].resp_strobe;
        assign lane_rdata[i] = i_resp[i].rdata & {$bits(dport_data_t){i_resp[i].resp_strobe}};
    end

    always_comb begin
        any_rdata = '0;
        for (int i = 0; i < CFG_CPU_MAX; i++) begin
            any_rdata = any_rdata | lane_rdata[i];
        end
    end

    // No slot answers a no_target request, so answer it here in step with the slots
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            no_target_q <= 1'b0;
            o_dport_resp_valid <= 1'b0;
            o_dport_resp_error <= 1'b0;
        end else begin
            no_target_q <= i_req.req_strobe & i_req.no_target;
            o_dport_resp_valid <= no_target_q | (|lane_strobe);
            o_dport_resp_error <= no_target_q | (|lane_error);
        end
    end

    always_ff @(posedge i_clk) begin
        o_dport_rdata <= no_target_q ? '0 : any_rdata;
    end

    assign o_resp_done = o_dport_resp_valid;

    // Empty positions arrive as zero
    assign o_halted = i_halted_slots;

endmodule : dport_resp_mux

`default_nettype wire

// File: verilog/workgroup.sv
// Workgroup top level with request decoder, hart slots and response mux
`default_nettype none

module workgroup #(
    parameter int cpu_num = 3
) (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  workgroup_pkg::hartsel_t    i_hartsel,
    input  logic                       i_haltreq,
    input  logic                       i_resumereq,
    input  logic                       i_dport_req_valid,
    input  logic                       i_dport_write,
    input  workgroup_pkg::dport_addr_u i_dport_addr,
    input  workgroup_pkg::dport_data_t i_dport_wdata,
    input  workgroup_pkg::hart_mask_t  i_msip,
    input  workgroup_pkg::hart_mask_t  i_mtip,
    input  workgroup_pkg::hart_mask_t  i_meip,
    input  workgroup_pkg::hart_mask_t  i_seip,
    output logic                       o_dport_req_ready,
    output logic                       o_dport_resp_valid,
    output logic                       o_dport_resp_error,
    output workgroup_pkg::dport_data_t o_dport_rdata,
    output workgroup_pkg::hart_mask_t  o_halted
);
    import workgroup_pkg::*;

    hart_mask_t halted_slots;
    logic resp_done;

    dport_req_if u_req_if ();
    dport_resp_if u_resp_if [CFG_CPU_MAX] ();

    dport_req_decoder #(
        .cpu_num(cpu_num)
    ) u_req_decoder (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_hartsel(i_hartsel),
        .i_haltreq(i_haltreq),
        .i_resumereq(i_resumereq),
        .i_dport_req_valid(i_dport_req_valid),
        .i_dport_write(i_dport_write),
        .i_dport_addr(i_dport_addr),
        .i_dport_wdata(i_dport_wdata),
        .i_resp_done(resp_done),
        .o_dport_req_ready(o_dport_req_ready),
        .o_req(u_req_if)
    );

    for (genvar i = 0; i < CFG_CPU_MAX; i++) begin : g_slot
        if (i < cpu_num) begin : g_hart
            hart_slot u_hart_slot (
                .i_clk(i_clk),
                .i_rst_n(i_rst_n),
                .i_hart_id(hartsel_t'(i)),
                .i_msip(i_msip[i]),
                .i_mtip(i_mtip[i]),
                .i_meip(i_meip[i]),
                .i_seip(i_seip[i]),
                .i_req(u_req_if),
                .o_resp(u_resp_if[i]),
                .o_halted(halted_slots[i])
            );
        end else begin : g_empty
            // Empty position never answers and never halts
            assign u_resp_if[i].resp_strobe = 1'b0;
            assign u_resp_if[i].resp_error = 1'b0;
            assign u_resp_if[i].rdata = '0;
            assign halted_slots[i] = 1'b0;
        end
    end

    dport_resp_mux u_resp_mux (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_halted_slots(halted_slots),
        .i_req(u_req_if),
        .i_resp(u_resp_if),
        .o_dport_resp_valid(o_dport_resp_valid),
        .o_dport_resp_error(o_dport_resp_error),
        .o_dport_rdata(o_dport_rdata),
        .o_resp_done(resp_done),
        .o_halted(o_halted)
    );

endmodule : workgroup

`default_nettype wire

// File: tests/workgroup_tb.sv
// Workgroup testbench that replays the operation file through the debug port and checks responses
`default_nettype none

module workgroup_tb;
    import workgroup_pkg::*;

    // Response pulse is the third edge when the acceptance edge counts as the first
    localparam int RESP_EDGES = 2;

    logic i_clk;
    logic i_rst_n;
    hartsel_t i_hartsel;
    logic i_haltreq;
    logic i_resumereq;
    logic i_dport_req_valid;
    logic i_dport_write;
    dport_addr_u i_dport_addr;
    dport_data_t i_dport_wdata;
    hart_mask_t i_msip;
    hart_mask_t i_mtip;
    hart_mask_t i_meip;
    hart_mask_t i_seip;
    logic o_dport_req_ready;
    logic o_dport_resp_valid;
    logic o_dport_resp_error;
    dport_data_t o_dport_rdata;
    hart_mask_t o_halted;

    // Steps loaded from the operation file
    string op_q[$];
    int hart_q[$];
    logic [11:0] addr_q[$];
    logic [31:0] data_q[$];
    logic err_q[$];
    logic [31:0] exp_q[$];

    // Halted mask expected after the last halt or resume step
    hart_mask_t halted_exp = '0;

    int cycle_count = 0;
    int cycle_limit = 0;

    workgroup #(
        .cpu_num(3)
    ) u_dut (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_hartsel(i_hartsel),
        .i_haltreq(i_haltreq),
        .i_resumereq(i_resumereq),
        .i_dport_req_valid(i_dport_req_valid),
        .i_dport_write(i_dport_write),
        .i_dport_addr(i_dport_addr),
        .i_dport_wdata(i_dport_wdata),
        .i_msip(i_msip),
        .i_mtip(i_mtip),
        .i_meip(i_meip),
        .i_seip(i_seip),
        .o_dport_req_ready(o_dport_req_ready),
        .o_dport_resp_valid(o_dport_resp_valid),
        .o_dport_resp_error(o_dport_resp_error),
        .o_dport_rdata(o_dport_rdata),
        .o_halted(o_halted)
    );

    always #5 i_clk = ~i_clk;

    task automatic check_rdata(input string name, input dport_data_t got, input dport_data_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_error(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_halted(input string name, input hart_mask_t got, input hart_mask_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    task automatic load_steps();
        int fd;
        int count;
        string line;
        string op;
        int hart;
        logic [11:0] addr;
        logic [31:0] data;
        int exp_err;
        logic [31:0] exp_val;
        fd = $fopen("tests/workgroup_tests.txt", "r");
        if (fd == 0) begin
            $display("The operation file tests/workgroup_tests.txt could not be opened");
            $display("Result: FAILED");
            $fatal(1);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                count = 0;
                if ($fgets(line, fd) > 0 && line.getc(0) != "#") begin
                    count = $sscanf(line, "%s %d %h %h %d %h",
                                    op, hart, addr, data, exp_err, exp_val);
                end
                if (count == 6 && (op == "H" || op == "U" || op == "I" ||
                                   op == "W" || op == "R")) begin
                    op_q.push_back(op);
                    hart_q.push_back(hart);
                    addr_q.push_back(addr);
                    data_q.push_back(data);
                    err_q.push_back(exp_err != 0);
                    exp_q.push_back(exp_val);
                end else if (count > 0) begin
                    $display("Malformed line in the operation file: %s", line);
                    $display("Result: FAILED");
                    $fatal(1);
                end
            end
            $fclose(fd);
        end
    endtask

    // One-cycle halt or resume pulse, o_halted follows on the second edge
    task automatic pulse_halt_resume(input logic halt, input hartsel_t hart,
                                     input hart_mask_t exp_mask);
        @(posedge i_clk);
        i_hartsel <= hart;
        i_haltreq <= halt;
        i_resumereq <= !halt;
        @(posedge i_clk);
        i_haltreq <= 1'b0;
        i_resumereq <= 1'b0;
        @(negedge i_clk);
        check_halted("o_halted", o_halted, halted_exp);
        @(negedge i_clk);
        check_halted("o_halted", o_halted, exp_mask);
        halted_exp = exp_mask;
    endtask

    // Bits 0 to 3 of lines are msip, mtip, seip and meip
    task automatic drive_interrupts(input int hart, input logic [3:0] lines);
        @(posedge i_clk);
        i_msip[hart] <= lines[0];
        i_mtip[hart] <= lines[1];
        i_seip[hart] <= lines[2];
        i_meip[hart] <= lines[3];
        repeat (2) @(posedge i_clk);
    endtask

    task automatic do_request(input logic is_write, input hartsel_t hart, input logic [11:0] addr,
                              input dport_data_t wdata, input logic exp_err,
                              input dport_data_t exp_data);
        int edges;
        @(posedge i_clk);
        i_hartsel <= hart;
        i_dport_write <= is_write;
        i_dport_addr.raw <= addr;
        i_dport_wdata <= wdata;
        i_dport_req_valid <= 1'b1;
        @(negedge i_clk);
        while (!o_dport_req_ready) begin
            @(negedge i_clk);
        end
        // Acceptance edge
        @(posedge i_clk);
        i_dport_req_valid <= 1'b0;
        edges = 0;
        @(negedge i_clk);
        while (!o_dport_resp_valid) begin
            check_error("o_dport_req_ready", o_dport_req_ready, 1'b0);
            @(posedge i_clk);
            edges++;
            @(negedge i_clk);
        end
        if (edges != RESP_EDGES) begin
            $display("ERR t=%0t response latency got %0d edges expected %0d",
                     $time, edges, RESP_EDGES);
            $display("Result: FAILED");
            $fatal(1);
        end
        check_error("o_dport_req_ready", o_dport_req_ready, 1'b0);
        check_error("o_dport_resp_error", o_dport_resp_error, exp_err);
        check_rdata("o_dport_rdata", o_dport_rdata, exp_err ? '0 : exp_data);
        @(negedge i_clk);
        check_error("o_dport_resp_valid", o_dport_resp_valid, 1'b0);
        check_error("o_dport_req_ready", o_dport_req_ready, 1'b1);
    endtask

    initial begin
        while (cycle_limit == 0 || cycle_count < cycle_limit) begin
            @(posedge i_clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the operation list did not complete", cycle_count);
        $display("Result: FAILED");
        $fatal(1);
    end

    initial begin
        int i;
        int gap;
        i_clk = 1'b0;
        i_rst_n = 1'b0;
        i_hartsel = '0;
        i_haltreq = 1'b0;
        i_resumereq = 1'b0;
        i_dport_req_valid = 1'b0;
        i_dport_write = 1'b0;
        i_dport_addr = '0;
        i_dport_wdata = '0;
        i_msip = '0;
        i_mtip = '0;
        i_meip = '0;
        i_seip = '0;
        void'($urandom(21));
        load_steps();
        cycle_limit = op_q.size() * 12 + 50;
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        check_error("o_dport_req_ready", o_dport_req_ready, 1'b1);
        check_error("o_dport_resp_valid", o_dport_resp_valid, 1'b0);
        check_error("o_dport_resp_error", o_dport_resp_error, 1'b0);
        check_halted("o_halted", o_halted, '0);
        for (i = 0; i < op_q.size(); i++) begin
            if (op_q[i] == "H" || op_q[i] == "U") begin
                pulse_halt_resume(op_q[i] == "H", hartsel_t'(hart_q[i]), exp_q[i][3:0]);
            end else if (op_q[i] == "I") begin
                drive_interrupts(hart_q[i], data_q[i][3:0]);
            end else begin
                do_request(op_q[i] == "W", hartsel_t'(hart_q[i]), addr_q[i], data_q[i],
                           err_q[i], exp_q[i]);
            end
            gap = $urandom_range(3, 0);
            repeat (gap) @(posedge i_clk);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule : workgroup_tb

`default_nettype wire

// File: workgroup.f
verilog/workgroup_pkg.sv
verilog/dport_req_if.sv
verilog/dport_resp_if.sv
verilog/dport_req_decoder.sv
verilog/hart_slot.sv
verilog/dport_resp_mux.sv
verilog/workgroup.sv
tests/workgroup_tb.sv

// File: tests/workgroup_tests.txt
# op hart addr(hex) data(hex) exp_err exp(hex), op is H halt, U resume, I interrupts, W write, R read
# H/U exp is the o_halted mask, I data bits 0..3 are msip mtip seip meip, R/W exp is rdata
H 0 000 00000000 0 00000001
H 2 000 00000000 0 00000005
R 0 000 00000000 0 00000001
R 1 000 00000000 0 00000000
W 0 403 cafe0001 0 00000000
R 0 403 00000000 0 cafe0001
W 2 400 12345678 0 00000000
R 2 400 00000000 0 12345678
U 0 000 00000000 0 00000004
U 2 000 00000000 0 00000000
R 0 000 00000000 0 00000000
W 0 403 deadbeef 1 00000000
R 0 403 00000000 0 cafe0001
W 2 400 87654321 1 00000000
R 2 400 00000000 0 12345678
I 1 000 0000000f 0 00000000
R 1 001 00000000 0 00000a88
I 1 000 00000005 0 00000000
R 1 001 00000000 0 00000208
I 1 000 00000000 0 00000000
R 1 001 00000000 0 00000000
R 0 001 00000000 0 00000000
R 3 000 00000000 1 00000000
W 3 400 11111111 1 00000000
H 3 000 00000000 0 00000000
R 0 800 00000000 1 00000000
R 1 c00 00000000 1 00000000
H 1 000 00000000 0 00000002
R 1 408 00000000 1 00000000
W 1 408 22222222 1 00000000
W 1 000 00000001 1 00000000
W 1 001 00000001 1 00000000
R 1 002 00000000 1 00000000
W 1 407 0badf00d 0 00000000
R 1 407 00000000 0 0badf00d
U 1 000 00000000 0 00000000
